// File: a_arbiter.f
a_definitions.sv
a_write_buffer.sv
a_master_port.sv
a_com_timer.sv
a_controller.sv
a_arbiter.sv
a_arbiter_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f a_arbiter.f --top-module a_arbiter_tb -o a_arbiter_sim

out=$(./obj_dir/a_arbiter_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

// File: a_arbiter_tb.sv
// arbiter testbench with serial master models, frame checks, directed tests and timeout
`default_nettype none

module a_arbiter_tb;

  ////////////////////////////////////////////////////////////////////////////
  // limits and reply frames with the first bit in time as the msb
  ////////////////////////////////////////////////////////////////////////////

  // six tests of up to 300 cycles plus a wide margin
  localparam int MAX_CYCLES = 4000;
  // longest single wait covers the 32 cycle slot
  localparam int WAIT_LIMIT = 100;

  localparam logic [2:0] GRANT_F  = 3'b110;
  localparam logic [2:0] RESUME_F = 3'b100;
  localparam logic [2:0] OPEN_F   = 3'b111;
  localparam logic [2:0] SPLIT_F  = 3'b010;

  logic       clk = 1'b0;
  logic       rstN;
  logic       m0_in;
  logic       m1_in;
  logic       m0_out;
  logic       m1_out;
  logic [1:0] slave_id;
  logic       slave_valid;

  int         cycle_count = 0;
  integer     seed;

  a_arbiter a_arbiter_inst (
    .clk         (clk),
    .rstN        (rstN),
    .m0_in       (m0_in),
    .m1_in       (m1_in),
    .m0_out      (m0_out),
    .m1_out      (m1_out),
    .slave_id    (slave_id),
    .slave_valid (slave_valid)
  );

  always #5 clk = ~clk;

  // hard stop for a hung run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run went past %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %0h, expected %0h",
               $time, name, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped on a failed wait");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // serial master models
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic out_line(input int m);
    return (m == 0) ? m0_out : m1_out;
  endfunction

  task automatic drive_line(input int m, input logic b);
    if (m == 0) begin
      m0_in = b;
    end else begin
      m1_in = b;
    end
  endtask

  // sends n bits msb first at one per cycle and then idles at 0
  task automatic send_bits(input int m, input logic [7:0] bits, input int n);
    for (int i = n - 1; i >= 0; i--) begin
      drive_line(m, bits[i]);
      @(negedge clk);
    end
    drive_line(m, 1'b0);
  endtask

  // header 1,1,1 then the id
  task automatic send_request(input int m, input logic [1:0] id);
    send_bits(m, {3'b000, 3'b111, id}, 5);
  endtask

  task automatic send_answer(input int m, input logic ack);
    send_bits(m, ack ? 8'b101 : 8'b110, 3);
  endtask

  task automatic send_end(input int m);
    send_bits(m, 8'b01, 2);
  endtask

  task automatic send_resume(input int m);
    send_bits(m, 8'b010, 3);
  endtask

  // sampled on the falling edge since the line moves on the rising one
  task automatic expect_frame(input int m, input logic [2:0] expected);
    int         waited;
    logic       prev;
    logic [2:0] got;
    waited = 0;
    prev   = 1'b0;
    while (out_line(m) !== 1'b1) begin
      prev = out_line(m);
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_failure($sformatf("no reply frame on m%0d_out within %0d cycles",
                                 m, WAIT_LIMIT));
      end
      @(negedge clk);
    end
    if (expected[2]) begin
      got[2] = 1'b1;
      @(negedge clk);
      got[1] = out_line(m);
      @(negedge clk);
      got[0] = out_line(m);
    end else begin
      // split frame opens with 0 so the first 1 is its middle bit
      got[2] = prev;
      got[1] = 1'b1;
      @(negedge clk);
      got[0] = out_line(m);
    end
    check_value($sformatf("m%0d_out frame", m), 32'(got), 32'(expected));
  endtask

  task automatic wait_valid(input logic level);
    int waited;
    waited = 0;
    while (slave_valid !== level) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_failure($sformatf("slave_valid did not go to %0b within %0d cycles",
                                 level, WAIT_LIMIT));
      end
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // transfer steps
  ////////////////////////////////////////////////////////////////////////////

  // bus out with the right slave and then the grant reply
  task automatic take_grant(input int m, input logic [1:0] id, input logic [2:0] frame);
    wait_valid(1'b1);
    check_value("slave_id", 32'(slave_id), 32'(id));
    expect_frame(m, frame);
  endtask

  // ack, open reply, end bits, bus dropped
  task automatic open_and_end(input int m);
    send_answer(m, 1'b1);
    expect_frame(m, OPEN_F);
    send_end(m);
    wait_valid(1'b0);
  endtask

  task automatic run_transfer(input int m, input logic [1:0] id);
    send_request(m, id);
    take_grant(m, id, GRANT_F);
    open_and_end(m);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    check_value("m0_out", 32'(m0_out), 32'd0);
    check_value("m1_out", 32'(m1_out), 32'd0);
    check_value("slave_valid", 32'(slave_valid), 32'd0);
    check_value("slave_id", 32'(slave_id), 32'd0);
  endtask

  task automatic test_nak();
    send_request(1, 2'd3);
    take_grant(1, 2'd3, GRANT_F);
    send_answer(1, 1'b0);
    wait_valid(1'b0);
    // release frame is all zeros and no open frame may show
    repeat (8) begin
      check_value("m1_out", 32'(m1_out), 32'd0);
      @(negedge clk);
    end
  endtask

  task automatic test_contention();
    fork
      send_request(0, 2'd1);
      send_request(1, 2'd3);
    join
    // port 0 wins and port 1 follows after the end
    take_grant(0, 2'd1, GRANT_F);
    open_and_end(0);
    take_grant(1, 2'd3, GRANT_F);
    open_and_end(1);
  endtask

  task automatic test_split();
    send_request(0, 2'd3);
    take_grant(0, 2'd3, GRANT_F);
    send_answer(0, 1'b1);
    expect_frame(0, OPEN_F);
    // master 0 keeps the bus while master 1 queues
    fork
      begin
        send_request(1, 2'd1);
        wait_valid(1'b0);
        take_grant(1, 2'd1, GRANT_F);
      end
      expect_frame(0, SPLIT_F);
    join
    open_and_end(1);
    // back with the slave it had before
    send_resume(0);
    take_grant(0, 2'd3, RESUME_F);
    open_and_end(0);
  endtask

  task automatic test_random();
    int         m;
    logic [1:0] id;
    repeat (8) begin
      m  = int'($unsigned($random(seed)) % 2);
      id = 2'(($unsigned($random(seed)) % 3) + 1);
      run_transfer(m, id);
    end
  endtask

  initial begin
    rstN  = 1'b0;
    m0_in = 1'b0;
    m1_in = 1'b0;
    seed  = 32'h7f05;
    repeat (3) @(negedge clk);
    test_reset();
    rstN = 1'b1;
    @(negedge clk);
    test_reset();

    run_transfer(0, 2'd2);
    test_nak();
    test_contention();
    test_split();
    test_random();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : a_arbiter_tb

`default_nettype wire

// File: a_arbiter.sv
// arbiter top: two master ports, controller and slot timer
`default_nettype none

module a_arbiter (
  input  logic                                clk,
  input  logic                                rstN,
  // master serial lines
  input  logic                                m0_in,
  input  logic                                m1_in,
  output logic                                m0_out,
  output logic                                m1_out,
  // selected slave
  output logic [a_definitions::S_ID_WIDTH-1:0] slave_id,
  output logic                                slave_valid
);
  import a_definitions::*;

  // port to controller
  logic [S_ID_WIDTH-1:0] id0;
  logic [S_ID_WIDTH-1:0] id1;
  mst_cmd_t              st0;
  mst_cmd_t              st1;
  logic                  done0;
  logic                  done1;
  // controller to port
  ctrl_cmd_t             cmd0;
  ctrl_cmd_t             cmd1;
  // slot timer
  logic                  timer_run;
  logic                  slot_over;

  a_master_port port0 (
    .clk       (clk),
    .rstN      (rstN),
    .port_in   (m0_in),
    .port_out  (m0_out),
    .cmd       (cmd0),
    .id        (id0),
    .com_state (st0),
    .done      (done0)
  );

  a_master_port port1 (
    .clk       (clk),
    .rstN      (rstN),
    .port_in   (m1_in),
    .port_out  (m1_out),
    .cmd       (cmd1),
    .id        (id1),
    .com_state (st1),
    .done      (done1)
  );

  a_controller ctrl (
    .clk         (clk),
    .rstN        (rstN),
    .id0         (id0),
    .id1         (id1),
    .st0         (st0),
    .st1         (st1),
    .done0       (done0),
    .done1       (done1),
    .cmd0        (cmd0),
    .cmd1        (cmd1),
    .slot_over   (slot_over),
    .timer_run   (timer_run),
    .slave_id    (slave_id),
    .slave_valid (slave_valid)
  );

  a_com_timer com_timer (
    .clk       (clk),
    .rstN      (rstN),
    .timer_run (timer_run),
    .slot_over (slot_over)
  );

endmodule : a_arbiter

`default_nettype wire

// File: a_controller.sv
// arbitration fsm with fixed priority grant, owner watch, split and resume
`default_nettype none

module a_controller (
  input  logic                                clk,
  input  logic                                rstN,
  // requests from the ports
  input  logic [a_definitions::S_ID_WIDTH-1:0] id0,
  input  logic [a_definitions::S_ID_WIDTH-1:0] id1,
  input  a_definitions::mst_cmd_t             st0,
  input  a_definitions::mst_cmd_t             st1,
  input  logic                                done0,
  input  logic                                done1,
  // commands to the ports
  output a_definitions::ctrl_cmd_t            cmd0,
  output a_definitions::ctrl_cmd_t            cmd1,
  // slot timer
  input  logic                                slot_over,
  output logic                                timer_run,
  // selected slave
  output logic [a_definitions::S_ID_WIDTH-1:0] slave_id,
  output logic                                slave_valid
);
  import a_definitions::*;

  typedef enum logic [1:0] {
    IDLE,
    GRANT,
    WAIT,
    OWN
  } arb_state_t;

  arb_state_t state;
  arb_state_t next_state;

  // port holding the bus
  logic                  owner;
  logic                  nxt_owner;
  // split masters and the slave they had
  logic [1:0]            parked;
  logic [S_ID_WIDTH-1:0] park_id0;
  logic [S_ID_WIDTH-1:0] park_id1;

  logic [1:0]            want;
  logic [S_ID_WIDTH-1:0] pick_id;
  mst_cmd_t              own_st;
  ctrl_cmd_t             own_cmd;
  logic                  split;
  logic                  release_bus;

  ////////////////////////////////////////////////////////////////////////////
  // request selection
  ////////////////////////////////////////////////////////////////////////////

  // new request, or a parked master ready to go on
  assign want[0] = (id0 != '0) || (done0 && parked[0]);
  assign want[1] = (id1 != '0) || (done1 && parked[1]);

  // port 0 first
  always_comb begin
    if (want[0]) begin
      nxt_owner = 1'b0;
      pick_id   = (done0 && parked[0]) ? park_id0 : id0;
    end else begin
      nxt_owner = 1'b1;
      pick_id   = (done1 && parked[1]) ? park_id1 : id1;
    end
  end

  assign own_st = owner ? st1 : st0;

  // slot spent and the other side is queued
  assign split = (state == OWN) && (own_st != END_COM) && slot_over && want[~owner];

  ////////////////////////////////////////////////////////////////////////////
  // fsm
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state  = state;
    own_cmd     = IDLE_C;
    release_bus = 1'b0;

    unique case (state)
      IDLE: begin
        if (|want) begin
          next_state = GRANT;
        end
      end

      // id is already latched so tell the port
      GRANT: begin
        own_cmd    = CLEAR;
        next_state = WAIT;
      end

      WAIT: begin
        if (own_st == NAK) begin
          release_bus = 1'b1;
        end else if (own_st == COM_) begin
          next_state = OWN;
        end
      end

      OWN: begin
        if (own_st == END_COM) begin
          release_bus = 1'b1;
        end else if (split) begin
          own_cmd     = STOP_S;
          release_bus = 1'b1;
        end
      end
    endcase

    if (release_bus) begin
      next_state = IDLE;
    end
  end

  // only the owner ever sees a command
  assign cmd0 = owner ? IDLE_C : own_cmd;
  assign cmd1 = owner ? own_cmd : IDLE_C;

  assign timer_run = (state == OWN);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state       <= IDLE;
      owner       <= 1'b0;
      parked      <= '0;
      slave_id    <= '0;
      slave_valid <= 1'b0;
    end else begin
      state <= next_state;

      // bus goes out on the edge into GRANT
      if ((state == IDLE) && (|want)) begin
        owner       <= nxt_owner;
        slave_id    <= pick_id;
        slave_valid <= 1'b1;
      end

      // resumed master is no longer parked
      if (state == GRANT) begin
        parked[owner] <= 1'b0;
      end

      if (split) begin
        parked[owner] <= 1'b1;
      end

      if (release_bus) begin
        slave_id    <= '0;
        slave_valid <= 1'b0;
      end
    end
  end

  // slave kept for the split master
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      park_id0 <= '0;
      park_id1 <= '0;
    end else begin
      if (split && !owner) begin
        park_id0 <= slave_id;
      end
      if (split && owner) begin
        park_id1 <= slave_id;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_one_cmd: assert property (
    @(posedge clk) disable iff (!rstN)
    !((cmd0 != IDLE_C) && (cmd1 != IDLE_C))
  );

  // a grant always names a real slave
  a_valid_id: assert property (
    @(posedge clk) disable iff (!rstN)
    $rose(slave_valid) |-> (slave_id != '0)
  );

endmodule : a_controller

`default_nettype wire

// File: a_com_timer.sv
// slot timer with a saturating cycle counter for the current bus owner
`default_nettype none

module a_com_timer (
  input  logic clk,
  input  logic rstN,
  input  logic timer_run,
  output logic slot_over
);
  import a_definitions::*;

  // same width as the slot length
  logic [$bits(COM_SLOT)-1:0] slot_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      slot_cnt <= '0;
    end else if (!timer_run) begin
      // back to zero without an owner
      slot_cnt <= '0;
    end else if (slot_cnt != COM_SLOT) begin
      slot_cnt <= slot_cnt + 1'b1;
    end
    // saturates at COM_SLOT until timer_run drops
  end

  // high from COM_SLOT cycles into the run
  // drops one cycle after timer_run falls
  assign slot_over = (slot_cnt == COM_SLOT);

endmodule : a_com_timer

`default_nettype wire

// File: a_master_port.sv
// master port: serial frame decoder, port fsm, reply serializer, cmd check
`default_nettype none

module a_master_port (
  input  logic                                clk,
  input  logic                                rstN,
  // serial lines to and from the master
  input  logic                                port_in,
  output logic                                port_out,
  // controller side
  input  a_definitions::ctrl_cmd_t            cmd,
  output logic [a_definitions::S_ID_WIDTH-1:0] id,
  output a_definitions::mst_cmd_t             com_state,
  output logic                                done
);
  import a_definitions::*;

  typedef enum logic [2:0] {
    RST,
    START,
    ALLOC1,
    ALLOC2,
    ACK,
    COM,
    DONE
  } port_state_t;

  port_state_t state;
  port_state_t next_state;

  // last three bits from the master, newest in bit 0
  logic [FRAME_W-1:0]    in_buf;
  logic                  buf_clr;
  // walking one, marks how many id bits are in
  logic [S_ID_WIDTH-1:0] id_mask;
  // set once the master has been split
  logic                  split_q;

  // reply frame to the serializer
  logic [FRAME_W-1:0]    write_val;
  logic                  write;
  logic [FRAME_W-1:0]    grant_frame;

  // frame matches on the input buffer
  logic                  hdr_hit;
  logic                  ack_hit;
  logic                  nak_hit;
  logic                  end_hit;
  logic                  res_hit;
  logic                  grant_take;

  ////////////////////////////////////////////////////////////////////////////
  // reply line
  ////////////////////////////////////////////////////////////////////////////

  a_write_buffer reply_buf (
    .clk  (clk),
    .rstN (rstN),
    .din  (write_val),
    .load (write),
    .dout (port_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // frame decode
  ////////////////////////////////////////////////////////////////////////////

  // request header 1,1,1
  assign hdr_hit = (in_buf == 3'b111);
  // answer to a grant
  assign ack_hit = (in_buf == 3'b101);
  assign nak_hit = (in_buf == 3'b110);
  // end of transfer 0,1
  assign end_hit = (in_buf[1:0] == 2'b01);
  // ready to resume after split, 0,1,0
  assign res_hit = (in_buf == 3'b010);

  // resume 1,0,0 after a split, else plain grant 1,1,0
  // frames are stored lsb first
  assign grant_frame = split_q ? 3'b001 : 3'b011;

  // grant lands in ALLOC2, or in DONE for a parked master
  assign grant_take = (cmd == CLEAR) && ((state == ALLOC2) || (state == DONE));

  ////////////////////////////////////////////////////////////////////////////
  // next state and reply
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state = state;
    write      = 1'b0;
    write_val  = '0;
    buf_clr    = 1'b0;

    unique case (state)
      // one settle cycle out of reset
      RST: next_state = START;

      START: begin
        if (hdr_hit) begin
          next_state = ALLOC1;
          buf_clr    = 1'b1;
        end
      end

      // collect the id bits msb first
      ALLOC1: begin
        if (id_mask[S_ID_WIDTH-1]) begin
          buf_clr = 1'b1;
          // id 0 is no request at all
          next_state = (in_buf[S_ID_WIDTH-1:0] != '0) ? ALLOC2 : START;
        end
      end

      ALLOC2: begin
        if (grant_take) begin
          write      = 1'b1;
          write_val  = grant_frame;
          next_state = ACK;
        end
      end

      ACK: begin
        if (nak_hit) begin
          // release 0,0,0
          write      = 1'b1;
          next_state = START;
          buf_clr    = 1'b1;
        end else if (ack_hit) begin
          // open 1,1,1
          write      = 1'b1;
          write_val  = 3'b111;
          next_state = COM;
          buf_clr    = 1'b1;
        end
      end

      COM: begin
        if (cmd == STOP_S) begin
          // split 0,1,0
          write      = 1'b1;
          write_val  = 3'b010;
          next_state = DONE;
          buf_clr    = 1'b1;
        end else if (cmd == STOP_P) begin
          write      = 1'b1;
          next_state = DONE;
          buf_clr    = 1'b1;
        end else if (end_hit) begin
          write      = 1'b1;
          next_state = START;
          buf_clr    = 1'b1;
        end
      end

      // parked, wait for resume frame and then the grant
      DONE: begin
        if (grant_take) begin
          write      = 1'b1;
          write_val  = grant_frame;
          next_state = ACK;
        end else if (res_hit) begin
          buf_clr = 1'b1;
        end
      end

      default: next_state = RST;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state, shift buffer, reports to controller
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= RST;
      in_buf    <= '0;
      id_mask   <= '0;
      id        <= '0;
      com_state <= END_COM;
      done      <= 1'b0;
      split_q   <= 1'b0;
    end else begin
      state <= next_state;

      // on a match keep only the bit arriving now
      if (buf_clr) begin
        in_buf <= {{(FRAME_W-1){1'b0}}, port_in};
      end else begin
        in_buf <= {in_buf[FRAME_W-2:0], port_in};
      end

      // first id bit arrives on the edge into ALLOC1
      if (state == ALLOC1) begin
        id_mask <= id_mask << 1;
      end else begin
        id_mask <= {{(S_ID_WIDTH-1){1'b0}}, 1'b1};
      end

      if ((state == ALLOC1) && id_mask[S_ID_WIDTH-1]) begin
        id <= in_buf[S_ID_WIDTH-1:0];
      end

      // granted, drop the request and wait for the answer
      if (grant_take) begin
        id        <= '0;
        com_state <= WAIT_ACK;
        done      <= 1'b0;
        split_q   <= 1'b0;
      end

      if (state == ACK) begin
        if (nak_hit) begin
          com_state <= NAK;
        end else if (ack_hit) begin
          com_state <= COM_;
        end
      end

      // split wins over an end in the same cycle
      if (state == COM) begin
        if (cmd == STOP_S) begin
          split_q <= 1'b1;
        end else if ((cmd != STOP_P) && end_hit) begin
          com_state <= END_COM;
        end
      end

      if ((state == DONE) && res_hit) begin
        done <= 1'b1;
      end
    end
  end

  // controller grants only a port that asked or a parked port
  a_clear_when_waiting: assert property (
    @(posedge clk) disable iff (!rstN)
    (cmd == CLEAR) |-> ((id != '0) || (state == DONE))
  );

endmodule : a_master_port

`default_nettype wire

// File: a_write_buffer.sv
// reply serializer with parallel load, lsb first shift, zero fill and overlap check
`default_nettype none

module a_write_buffer (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [a_definitions::FRAME_W-1:0] din,
  input  logic                             load,
  output logic                             dout
);
  import a_definitions::*;

  // frame being shifted out
  logic [FRAME_W-1:0] shift_q;
  // one bit per frame bit still to go out
  logic [FRAME_W-1:0] busy_q;

  // idle line sits at 0
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      shift_q <= '0;
      busy_q  <= '0;
    end else if (load) begin
      shift_q <= din;
      busy_q  <= '1;
    end else begin
      // zeros come in from the top
      shift_q <= shift_q >> 1;
      busy_q  <= busy_q >> 1;
    end
  end

  // first bit shows the cycle after load
  assign dout = shift_q[0];

  // a new frame may only land on the last bit of the old one
  a_no_overlap: assert property (
    @(posedge clk) disable iff (!rstN)
    load |-> (busy_q[FRAME_W-1:1] == '0)
  );

endmodule : a_write_buffer

`default_nettype wire

// File: a_definitions.sv
// arbiter package: slave count, id width, slot length, frame width, command enums
`default_nettype none

package a_definitions;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  // addressable slaves, ids 1..NO_SLAVES
  localparam int NO_SLAVES = 3;

  // id 0 is reserved for "no slave"
  localparam int S_ID_WIDTH = $clog2(NO_SLAVES + 1);

  // cycles an owner keeps the bus before it may be split
  // typed so the slot counter takes its width from here
  localparam logic [5:0] COM_SLOT = 6'd32;

  // bits in one reply frame to a master
  localparam int FRAME_W = 3;

  ////////////////////////////////////////////////////////////////////////////
  // commands
  ////////////////////////////////////////////////////////////////////////////

  // controller to port, one cycle per command
  typedef enum logic [1:0] {
    IDLE_C,  // nothing
    CLEAR,   // grant
    STOP_S,  // split
    STOP_P   // preempt, decoded by the port only
  } ctrl_cmd_t;

  // port to controller, state of the attached master
  typedef enum logic [1:0] {
    END_COM,   // transfer over
    NAK,       // master refused the grant
    WAIT_ACK,  // grant sent, no answer yet
    COM_       // master is transferring
  } mst_cmd_t;

endpackage

`default_nettype wire
